//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_kl_ebus_top
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- common/kl_ebus_pkg.sv
`default_nettype none

package kl_ebus_pkg;

  // KL10 numbering, bit 0 is the most significant
  typedef logic [0:35] ebus_word_t;
  typedef logic [0:6] ebus_cs_t;
  typedef logic [0:6] ebus_ds_t;

  typedef struct packed {
    logic       driving;
    ebus_word_t data;
  } ebus_driver_t;

  typedef struct packed {ebus_cs_t cs; ebus_ds_t ds; logic diag_strobe; logic write; ebus_word_t wdata;} ebus_cycle_t;

  // Controller selects
  localparam ebus_cs_t CS_EDP = 7'o10;
  localparam ebus_cs_t CS_MBOX = 7'o20;

  // Diagnostic functions
  localparam ebus_ds_t DS_AR = 7'o00;
  localparam ebus_ds_t DS_MEM_ADR = 7'o01;
  localparam ebus_ds_t DS_MEM_DATA = 7'o02;
  localparam ebus_ds_t DS_MEM_GO = 7'o03;
  localparam ebus_ds_t DS_MEM_STATUS = 7'o04;

  // Status bits counted from the least significant end
  localparam int STATUS_BUSY_BIT = 0;
  localparam int STATUS_DONE_BIT = 1;
  localparam int STATUS_PAR_ERR_BIT = 2;

  // EDP datapath group
  localparam int EDP_SLICES = 6;
  localparam int EDP_FIELD_BITS = 6;

endpackage

`default_nettype wire

//--- common/kl_mbus_pkg.sv
`default_nettype none

package kl_mbus_pkg;

  // Physical address PMA 14 to 35
  typedef logic [14:35] mbus_adr_t;

  localparam int MEM_WORDS = 1024;
  localparam int MEM_ADR_BITS = $clog2(MEM_WORDS);
  localparam int MEM_READ_DELAY = 3;

  typedef logic [MEM_ADR_BITS-1:0] mem_idx_t;
  typedef logic [$clog2(MEM_READ_DELAY+1)-1:0] mem_delay_t;

  typedef struct packed {
    logic                   start_a;
    logic                   wr_rq;
    logic                   rd_rq;
    mbus_adr_t              adr;
    kl_ebus_pkg::ebus_word_t d_out;
    logic                   par_out;
  } mbus_req_t;

  typedef struct packed {
    logic                   ackn_a;
    logic                   data_valid_a;
    kl_ebus_pkg::ebus_word_t d_in;
    logic                   par_in;
  } mbus_rsp_t;

endpackage

`default_nettype wire

//--- mbox/mb20_memory.sv
`timescale 1ns/1ps
`default_nettype none

module mb20_memory (
  input  logic                    clk,
  input  logic                    reset,
  input  kl_mbus_pkg::mbus_req_t  mbus_req,
  output kl_mbus_pkg::mbus_rsp_t  mbus_rsp
);

  // Word in the upper 36 bits, parity in bit 0
  logic [36:0]             mem [kl_mbus_pkg::MEM_WORDS];
  kl_mbus_pkg::mem_idx_t   idx;
  kl_mbus_pkg::mem_idx_t   rd_idx;
  kl_mbus_pkg::mem_delay_t delay_cnt;
  logic                    accept;

  // Low address bits only, higher addresses alias
  assign idx = mbus_req.adr[36-kl_mbus_pkg::MEM_ADR_BITS:35];
  assign accept = mbus_req.start_a && !mbus_rsp.ackn_a;

  always_ff @(posedge clk) begin
    if (accept && mbus_req.wr_rq) begin
      mem[idx] <= {mbus_req.d_out, mbus_req.par_out};
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mbus_rsp.ackn_a <= 1'b0;
      mbus_rsp.data_valid_a <= 1'b0;
      mbus_rsp.d_in <= '0;
      mbus_rsp.par_in <= 1'b0;
      rd_idx <= '0;
      delay_cnt <= '0;
    end else begin
      mbus_rsp.ackn_a <= accept;
      mbus_rsp.data_valid_a <= 1'b0;
      if (accept && mbus_req.rd_rq) begin
        rd_idx <= idx;
        delay_cnt <= kl_mbus_pkg::mem_delay_t'(kl_mbus_pkg::MEM_READ_DELAY);
      end else if (delay_cnt != '0) begin
        delay_cnt <= delay_cnt - 1'b1;
        if (delay_cnt == kl_mbus_pkg::mem_delay_t'(1)) begin
          mbus_rsp.data_valid_a <= 1'b1;
          {mbus_rsp.d_in, mbus_rsp.par_in} <= mem[rd_idx];
        end
      end
    end
  end

  a_no_start_during_read: assert property (@(posedge clk) disable iff (reset)
    accept |-> (delay_cnt == '0) && !mbus_rsp.data_valid_a);

endmodule

`default_nettype wire

//--- mbox/mbox_port.sv
`timescale 1ns/1ps
`default_nettype none

module mbox_port (
  input  logic                       clk,
  input  logic                       reset,
  input  kl_ebus_pkg::ebus_cycle_t   cycle,
  input  kl_ebus_pkg::ebus_word_t    ebus_data,
  output kl_ebus_pkg::ebus_driver_t  driver,
  output kl_mbus_pkg::mbus_req_t     mbus_req,
  input  kl_mbus_pkg::mbus_rsp_t     mbus_rsp
);

  typedef enum logic [1:0] {st_idle, st_wait_ack, st_wait_data, st_finish} mbox_state_t;

  mbox_state_t             state;
  kl_mbus_pkg::mbus_adr_t  adr_q;
  kl_ebus_pkg::ebus_word_t data_q;
  logic                    write_op;
  logic                    done;
  logic                    par_err;
  logic                    busy;
  logic                    sel;
  logic                    go;

  assign sel = cycle.diag_strobe && (cycle.cs == kl_ebus_pkg::CS_MBOX);
  assign busy = (state == st_wait_ack) || (state == st_wait_data);
  assign go = sel && cycle.write && (cycle.ds == kl_ebus_pkg::DS_MEM_GO);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      adr_q <= '0;
      data_q <= '0;
      write_op <= 1'b0;
      done <= 1'b0;
      par_err <= 1'b0;
    end else begin
      if (sel && cycle.write && cycle.ds == kl_ebus_pkg::DS_MEM_ADR) begin
        adr_q <= ebus_data[14:35];
      end
      if (sel && cycle.write && cycle.ds == kl_ebus_pkg::DS_MEM_DATA) begin
        data_q <= ebus_data;
      end
      case (state)
        st_wait_ack: begin
          if (mbus_rsp.ackn_a) begin
            if (write_op) begin
              done <= 1'b1;
              state <= st_finish;
            end else begin
              state <= st_wait_data;
            end
          end
        end
        st_wait_data: begin
          if (mbus_rsp.data_valid_a) begin
            data_q <= mbus_rsp.d_in;
            // Odd parity over the word and the parity bit
            par_err <= ~^{mbus_rsp.d_in, mbus_rsp.par_in};
            done <= 1'b1;
            state <= st_finish;
          end
        end
        default: begin
          // Bit 35 of the go word selects a write
          if (go) begin
            write_op <= ebus_data[35];
            done <= 1'b0;
            par_err <= 1'b0;
            state <= st_wait_ack;
          end else begin
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_comb begin
    mbus_req.start_a = (state == st_wait_ack);
    mbus_req.wr_rq = mbus_req.start_a && write_op;
    mbus_req.rd_rq = mbus_req.start_a && !write_op;
    mbus_req.adr = adr_q;
    mbus_req.d_out = data_q;
    mbus_req.par_out = ~^data_q;
  end

  always_comb begin
    driver.driving = 1'b0;
    driver.data = '0;
    if (sel && !cycle.write) begin
      case (cycle.ds)
        kl_ebus_pkg::DS_MEM_ADR: begin
          driver.driving = 1'b1;
          driver.data[14:35] = adr_q;
        end
        kl_ebus_pkg::DS_MEM_DATA: begin
          driver.driving = 1'b1;
          driver.data = data_q;
        end
        kl_ebus_pkg::DS_MEM_STATUS: begin
          driver.driving = 1'b1;
          driver.data[35 - kl_ebus_pkg::STATUS_BUSY_BIT] = busy;
          driver.data[35 - kl_ebus_pkg::STATUS_DONE_BIT] = done;
          driver.data[35 - kl_ebus_pkg::STATUS_PAR_ERR_BIT] = par_err;
        end
        default: driver.driving = 1'b0;
      endcase
    end
  end

  // A memory cycle starts only from a go that found the port free
  a_start_after_go: assert property (@(posedge clk) disable iff (reset)
    $rose(mbus_req.start_a) |-> $past(go && !busy));

endmodule

`default_nettype wire

//--- rtl/ebus_front_end.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_front_end (
  input  logic                       clk,
  input  logic                       reset,
  input  logic [15:0]                awaddr,
  input  logic                       awvalid,
  output logic                       awready,
  input  logic [63:0]                wdata,
  input  logic [7:0]                 wstrb,
  input  logic                       wvalid,
  output logic                       wready,
  output logic [1:0]                 bresp,
  output logic                       bvalid,
  input  logic                       bready,
  input  logic [15:0]                araddr,
  input  logic                       arvalid,
  output logic                       arready,
  output logic [63:0]                rdata,
  output logic [1:0]                 rresp,
  output logic                       rvalid,
  input  logic                       rready,
  input  kl_ebus_pkg::ebus_word_t    ebus_data,
  output kl_ebus_pkg::ebus_cycle_t   cycle,
  output kl_ebus_pkg::ebus_driver_t  fe_driver
);

  typedef enum logic [1:0] {st_idle, st_strobe, st_respond} fe_state_t;

  fe_state_t               state;
  logic                    write_q;
  kl_ebus_pkg::ebus_cs_t   cs_q;
  kl_ebus_pkg::ebus_ds_t   ds_q;
  kl_ebus_pkg::ebus_word_t wdata_q;
  kl_ebus_pkg::ebus_word_t rdata_q;
  logic [63:0]             wdata_m;

  // Unstrobed bytes write as zero
  always_comb begin
    for (int b = 0; b < 8; b++) begin
      wdata_m[b*8 +: 8] = wstrb[b] ? wdata[b*8 +: 8] : 8'h00;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      awready <= 1'b0;
      wready <= 1'b0;
      arready <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
      write_q <= 1'b0;
      cs_q <= '0;
      ds_q <= '0;
      wdata_q <= '0;
      rdata_q <= '0;
    end else begin
      awready <= 1'b0;
      wready <= 1'b0;
      arready <= 1'b0;
      case (state)
        st_idle: begin
          if (awready || arready) begin
            // Handshake completes this cycle, strobe follows
            state <= st_strobe;
          end else if (awvalid && wvalid) begin
            awready <= 1'b1;
            wready <= 1'b1;
            write_q <= 1'b1;
            cs_q <= awaddr[15:9];
            ds_q <= awaddr[8:2];
            wdata_q <= wdata_m[35:0];
          end else if (arvalid) begin
            arready <= 1'b1;
            write_q <= 1'b0;
            cs_q <= araddr[15:9];
            ds_q <= araddr[8:2];
          end
        end
        st_strobe: begin
          if (write_q) begin
            bvalid <= 1'b1;
          end else begin
            rvalid <= 1'b1;
            rdata_q <= ebus_data;
          end
          state <= st_respond;
        end
        default: begin
          if (bvalid && bready) begin
            bvalid <= 1'b0;
            state <= st_idle;
          end
          if (rvalid && rready) begin
            rvalid <= 1'b0;
            state <= st_idle;
          end
        end
      endcase
    end
  end

  always_comb begin
    cycle.cs = cs_q;
    cycle.ds = ds_q;
    cycle.diag_strobe = (state == st_strobe);
    cycle.write = write_q;
    cycle.wdata = wdata_q;
    fe_driver.driving = cycle.diag_strobe && write_q;
    fe_driver.data = cycle.wdata;
  end

  assign bresp = 2'b00;
  assign rresp = 2'b00;
  assign rdata = {28'd0, rdata_q};

  a_one_response: assert property (@(posedge clk) disable iff (reset) !(bvalid && rvalid));

endmodule

`default_nettype wire

//--- rtl/ebus_mux.sv
`timescale 1ns/1ps
`default_nettype none

module ebus_mux (
  input  kl_ebus_pkg::ebus_driver_t fe,
  input  kl_ebus_pkg::ebus_driver_t edp [kl_ebus_pkg::EDP_SLICES],
  input  kl_ebus_pkg::ebus_driver_t mbox,
  output kl_ebus_pkg::ebus_word_t   data
);

  logic                    edp_any;
  kl_ebus_pkg::ebus_word_t edp_data;

  // Each slice owns only its own field of the group word
  always_comb begin
    edp_any = 1'b0;
    for (int i = 0; i < kl_ebus_pkg::EDP_SLICES; i++) begin
      edp_any = edp_any | edp[i].driving;
      edp_data[i*kl_ebus_pkg::EDP_FIELD_BITS +: kl_ebus_pkg::EDP_FIELD_BITS] =
        edp[i].data[i*kl_ebus_pkg::EDP_FIELD_BITS +: kl_ebus_pkg::EDP_FIELD_BITS];
    end
  end

  always_comb begin
    if (fe.driving) begin
      data = fe.data;
    end else if (edp_any) begin
      data = edp_data;
    end else if (mbox.driving) begin
      data = mbox.data;
    end else begin
      data = '0;
    end
  end

  // Front end drives only on writes, MBOX only on reads
  always_comb begin
    a_fe_mbox_excl: assert (!(fe.driving && mbox.driving));
  end

endmodule

`default_nettype wire

//--- rtl/edp_slice.sv
`timescale 1ns/1ps
`default_nettype none

module edp_slice #(
  parameter int SLICE = 0
) (
  input  logic                       clk,
  input  logic                       reset,
  input  kl_ebus_pkg::ebus_cycle_t   cycle,
  input  kl_ebus_pkg::ebus_word_t    ebus_data,
  output kl_ebus_pkg::ebus_driver_t  driver
);

  logic [0:kl_ebus_pkg::EDP_FIELD_BITS-1] ar_field;
  logic                                   ar_sel;

  assign ar_sel = cycle.diag_strobe && (cycle.cs == kl_ebus_pkg::CS_EDP) &&
                  (cycle.ds == kl_ebus_pkg::DS_AR);

  always_ff @(posedge clk) begin
    if (reset) begin
      ar_field <= '0;
    end else if (ar_sel && cycle.write) begin
      ar_field <= ebus_data[SLICE*kl_ebus_pkg::EDP_FIELD_BITS +: kl_ebus_pkg::EDP_FIELD_BITS];
    end
  end

  // Read data goes out in the same bit positions it was loaded from
  always_comb begin
    driver.driving = ar_sel && !cycle.write;
    driver.data = '0;
    driver.data[SLICE*kl_ebus_pkg::EDP_FIELD_BITS +: kl_ebus_pkg::EDP_FIELD_BITS] = ar_field;
  end

endmodule

`default_nettype wire

//--- rtl/kl_ebus_top.sv
`timescale 1ns/1ps
`default_nettype none

module kl_ebus_top (
  input  logic        clk,
  input  logic        reset,
  input  logic [15:0] awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [63:0] wdata,
  input  logic [7:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [15:0] araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [63:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  kl_ebus_pkg::ebus_cycle_t  cycle;
  kl_ebus_pkg::ebus_word_t   ebus_data;
  kl_ebus_pkg::ebus_driver_t fe_driver;
  kl_ebus_pkg::ebus_driver_t mbox_driver;
  kl_ebus_pkg::ebus_driver_t edp_driver [kl_ebus_pkg::EDP_SLICES];
  kl_mbus_pkg::mbus_req_t    mbus_req;
  kl_mbus_pkg::mbus_rsp_t    mbus_rsp;

  ebus_front_end u_front_end (.*);

  ebus_mux u_mux (
    .fe   (fe_driver),
    .edp  (edp_driver),
    .mbox (mbox_driver),
    .data (ebus_data)
  );

  for (genvar i = 0; i < kl_ebus_pkg::EDP_SLICES; i++) begin : g_edp
    edp_slice #(.SLICE(i)) u_edp (
      .clk       (clk),
      .reset     (reset),
      .cycle     (cycle),
      .ebus_data (ebus_data),
      .driver    (edp_driver[i])
    );
  end

  mbox_port u_mbox (
    .clk       (clk),
    .reset     (reset),
    .cycle     (cycle),
    .ebus_data (ebus_data),
    .driver    (mbox_driver),
    .mbus_req  (mbus_req),
    .mbus_rsp  (mbus_rsp)
  );

  mb20_memory u_memory (.*);

endmodule

`default_nettype wire

//--- tb/tb_kl_ebus_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_kl_ebus_top;

  localparam int TIMEOUT_CYCLES = 50;
  localparam int POLL_LIMIT = 20;
  localparam int RUN_LIMIT = 20000;
  localparam logic [63:0] WORD_MASK = 64'h0000_000f_ffff_ffff;
  localparam logic [6:0] CS_NONE = 7'o77;

  logic        clk;
  logic        reset;
  logic [15:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [15:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [63:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;

  integer      seed = 32'hf99d164b;
  int          errors = 0;
  int          errors_at_start = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          stall_max = 0;
  logic        timed_out = 1'b0;
  string       timeout_what;
  logic [63:0] word;
  logic [63:0] rd_word;
  logic [63:0] ar_model;
  logic [21:0] adr;
  logic [21:0] adr_list [6];
  logic [63:0] word_list [6];
  logic [63:0] expected;

  kl_ebus_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Ends the run when a wait gives up, or when the whole run takes too long
  initial begin : watchdog
    int n;
    n = 0;
    while (!timed_out && n < RUN_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (timed_out) $display("timeout while waiting for %s", timeout_what);
    else $display("timeout, run exceeded %0d cycles", RUN_LIMIT);
    $display("SIMULATION FAILED");
    $finish;
  end

  a_bvalid_held: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $display("mismatch at %0t: bvalid or bresp changed before bready", $time);
      errors++;
    end

  a_rvalid_held: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
      $display("mismatch at %0t: rvalid, rdata or rresp changed before rready", $time);
      errors++;
    end

  a_upper_zero: assert property (@(posedge clk) disable iff (reset)
    rvalid |-> rdata[63:36] == '0)
    else begin
      $display("mismatch at %0t: rdata bits above 35 not zero", $time);
      errors++;
    end

  task automatic give_up(input string what);
    timeout_what = what;
    timed_out = 1'b1;
    // Parked here until the watchdog sees the flag
    forever @(posedge clk);
  endtask

  task automatic check_eq(input string what, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic stall_cycles();
    int n;
    n = (stall_max == 0) ? 0 : int'($unsigned($random(seed)) % (stall_max + 1));
    repeat (n) @(posedge clk);
  endtask

  task automatic axi_write(input logic [6:0] cs, input logic [6:0] ds, input logic [63:0] data);
    int n;
    awaddr <= {cs, ds, 2'b00};
    awvalid <= 1'b1;
    wdata <= data;
    wstrb <= 8'hff;
    wvalid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!(awready && wready) && n < TIMEOUT_CYCLES);
    if (!(awready && wready)) give_up("awready and wready");
    awvalid <= 1'b0;
    wvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!bvalid && n < TIMEOUT_CYCLES);
    if (!bvalid) give_up("bvalid");
    check_eq("bresp", {62'd0, bresp}, 64'd0);
    stall_cycles();
    bready <= 1'b1;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic axi_read(input logic [6:0] cs, input logic [6:0] ds, output logic [63:0] data);
    int n;
    araddr <= {cs, ds, 2'b00};
    arvalid <= 1'b1;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!arready && n < TIMEOUT_CYCLES);
    if (!arready) give_up("arready");
    arvalid <= 1'b0;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (!rvalid && n < TIMEOUT_CYCLES);
    if (!rvalid) give_up("rvalid");
    check_eq("rresp", {62'd0, rresp}, 64'd0);
    stall_cycles();
    data = rdata;
    rready <= 1'b1;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  // Status must end with done set, busy and parity error clear
  task automatic poll_done();
    logic [63:0] st;
    int n;
    n = 0;
    do begin
      axi_read(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_STATUS, st);
      n++;
    end while (st[kl_ebus_pkg::STATUS_BUSY_BIT] && n < POLL_LIMIT);
    if (st[kl_ebus_pkg::STATUS_BUSY_BIT]) give_up("MBOX busy to clear");
    check_eq("status after cycle", st, 64'(1) << kl_ebus_pkg::STATUS_DONE_BIT);
  endtask

  task automatic mem_write(input logic [21:0] a, input logic [63:0] data);
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_ADR, {42'd0, a});
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_DATA, data);
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_GO, 64'd1);
    poll_done();
  endtask

  task automatic mem_read(input logic [21:0] a, output logic [63:0] data);
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_ADR, {42'd0, a});
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_GO, 64'd0);
    poll_done();
    axi_read(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_DATA, data);
  endtask

  task automatic start_test();
    errors_at_start = errors;
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors == errors_at_start) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name, errors - errors_at_start);
    end
  endtask

  task automatic ar_round_trips(input int count);
    for (int i = 0; i < count; i++) begin
      word = {$random(seed), $random(seed)};
      axi_write(kl_ebus_pkg::CS_EDP, kl_ebus_pkg::DS_AR, word);
      axi_read(kl_ebus_pkg::CS_EDP, kl_ebus_pkg::DS_AR, rd_word);
      check_eq("AR", rd_word, word & WORD_MASK);
    end
    ar_model = word & WORD_MASK;
  endtask

  initial begin
    reset = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    start_test();
    axi_read(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_STATUS, rd_word);
    check_eq("status after reset", rd_word, 64'd0);
    end_test("reset status");

    start_test();
    ar_round_trips(8);
    end_test("edp ar write and read");

    start_test();
    adr = 22'($random(seed));
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_ADR, {42'd0, adr});
    axi_read(CS_NONE, kl_ebus_pkg::DS_AR, rd_word);
    check_eq("unmapped read", rd_word, 64'd0);
    axi_write(CS_NONE, kl_ebus_pkg::DS_AR, {$random(seed), $random(seed)});
    axi_write(CS_NONE, kl_ebus_pkg::DS_MEM_ADR, {$random(seed), $random(seed)});
    axi_write(CS_NONE, kl_ebus_pkg::DS_MEM_GO, 64'd1);
    axi_read(kl_ebus_pkg::CS_EDP, kl_ebus_pkg::DS_AR, rd_word);
    check_eq("AR after unmapped write", rd_word, ar_model);
    axi_read(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_ADR, rd_word);
    check_eq("address after unmapped write", rd_word, {42'd0, adr});
    axi_read(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_STATUS, rd_word);
    check_eq("status after unmapped go", rd_word, 64'd0);
    end_test("unmapped controllers");

    start_test();
    for (int i = 0; i < 6; i++) begin
      adr_list[i] = 22'($random(seed));
      word_list[i] = {$random(seed), $random(seed)} & WORD_MASK;
      mem_write(adr_list[i], word_list[i]);
    end
    // Later writes win where the addresses meet modulo the memory size
    for (int i = 0; i < 6; i++) begin
      expected = word_list[i];
      for (int j = i + 1; j < 6; j++) begin
        if (adr_list[j] % kl_mbus_pkg::MEM_WORDS ==
            adr_list[i] % kl_mbus_pkg::MEM_WORDS) begin
          expected = word_list[j];
        end
      end
      mem_read(adr_list[i], rd_word);
      check_eq("memory word", rd_word, expected);
    end
    end_test("memory write then read");

    start_test();
    for (int i = 1; i <= 3; i++) begin
      adr = 22'($unsigned($random(seed)) % kl_mbus_pkg::MEM_WORDS);
      word = {$random(seed), $random(seed)} & WORD_MASK;
      mem_write(adr, word);
      mem_read(adr + 22'(i * kl_mbus_pkg::MEM_WORDS), rd_word);
      check_eq("aliased word", rd_word, word);
    end
    end_test("address aliasing");

    start_test();
    stall_max = 5;
    ar_round_trips(6);
    adr = 22'($random(seed));
    word = {$random(seed), $random(seed)} & WORD_MASK;
    mem_write(adr, word);
    stall_max = 0;
    // Data register differs from memory, so a second write cycle would show
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_DATA, ~word & WORD_MASK);
    // The read keeps the port busy while the next go arrives
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_GO, 64'd0);
    axi_write(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_GO, 64'd1);
    poll_done();
    axi_read(kl_ebus_pkg::CS_MBOX, kl_ebus_pkg::DS_MEM_DATA, rd_word);
    check_eq("data after ignored go", rd_word, word);
    mem_read(adr, rd_word);
    check_eq("memory after ignored go", rd_word, word);
    end_test("back-pressure and go while busy");

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
common/kl_ebus_pkg.sv
common/kl_mbus_pkg.sv
rtl/ebus_front_end.sv
rtl/ebus_mux.sv
rtl/edp_slice.sv
mbox/mbox_port.sv
mbox/mb20_memory.sv
rtl/kl_ebus_top.sv
tb/tb_kl_ebus_top.sv
